/* logic/procPkg.sv */
// Processor shared definitions
package procPkg;

   localparam int dataWidth     = 16;
   localparam int regAddrWidth  = 3;
   localparam int instWords     = 64;
   localparam int dataWords     = 64;
   localparam int instAddrWidth = $clog2(instWords);
   localparam int dataAddrWidth = $clog2(dataWords);

   // Opcode lives in inst[15:11]
   typedef enum logic [4:0] {
      OpHalt = 5'b00000,
      OpNop  = 5'b00001,
      OpAdd  = 5'b00010,
      OpSub  = 5'b00011,
      OpAnd  = 5'b00100,
      OpXor  = 5'b00101,
      OpAddi = 5'b00110,
      OpLd   = 5'b00111,
      OpSt   = 5'b01000
   } opcodeT;

   typedef enum logic [1:0] {Add, Sub, And, Xor} aluOpT;

   typedef enum logic [1:0] {FromReg, FromExMem, FromMemWb} fwdSelT;

   localparam logic [dataWidth-1:0] nopInst = {OpNop, 11'b0};

   typedef struct packed {
      logic [dataWidth-1:0] inst;
   } ifIdT;

   typedef struct packed {
      logic [dataWidth-1:0]    rsVal;
      logic [dataWidth-1:0]    rtVal;
      logic [regAddrWidth-1:0] rsAddr;
      logic [regAddrWidth-1:0] rtAddr;
      logic [dataWidth-1:0]    imm;
      logic [regAddrWidth-1:0] rdAddr;
      aluOpT                   aluOp;
      logic                    useImm;
      logic                    regWrite;
      logic                    memRead;
      logic                    memWrite;
      logic                    isHalt;
   } idExT;

   typedef struct packed {
      logic [dataWidth-1:0]    aluRes;
      logic [dataWidth-1:0]    storeData;
      logic [regAddrWidth-1:0] rtAddr;
      logic [regAddrWidth-1:0] rdAddr;
      logic                    regWrite;
      logic                    memRead;
      logic                    memWrite;
      logic                    isHalt;
   } exMemT;

   typedef struct packed {
      logic [dataWidth-1:0]    wrData;
      logic [regAddrWidth-1:0] rdAddr;
      logic                    regWrite;
      logic                    isHalt;
   } memWbT;

   // Bubble contents of each stage register
   localparam ifIdT  ifIdBubble  = '{inst: nopInst};
   localparam idExT  idExBubble  = '0;
   localparam exMemT exMemBubble = '0;
   localparam memWbT memWbBubble = '0;

endpackage

/* logic/pipeReg.sv */
// Pipeline stage register
`timescale 1ns/100ps

module pipeReg #(
   parameter type payloadT = logic
) (
   input  logic    clk,
   input  logic    arstN,
   input  logic    hold,
   input  logic    bubble,
   input  payloadT bubbleValue,
   input  payloadT dIn,
   output payloadT dOut
);

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         dOut <= bubbleValue;
      end else if (!hold) begin
         if (bubble) begin
            dOut <= bubbleValue;
         end else begin
            dOut <= dIn;
         end
      end
   end

   // A load-use bubble must never coincide with the halt freeze
   holdBubbleExclusive: assert property (
      @(posedge clk) disable iff (!arstN) !(hold && bubble)
   ) else $error("stage register asked to hold and bubble at once");

endmodule

/* logic/fetchStage.sv */
// Instruction fetch
`timescale 1ns/100ps

module fetchStage (
   input  logic                              clk,
   input  logic                              arstN,
   input  logic                              run,
   input  logic                              stall,
   input  logic                              progWe,
   input  logic [procPkg::instAddrWidth-1:0] progAddr,
   input  logic [procPkg::dataWidth-1:0]     progData,
   output logic [procPkg::dataWidth-1:0]     inst
);

   logic [procPkg::instAddrWidth-1:0] pc;
   logic [procPkg::dataWidth-1:0]     imem [procPkg::instWords];

   // Program load port
   always_ff @(posedge clk) begin
      if (progWe) begin
         imem[progAddr] <= progData;
      end
   end

   // PC starts at zero and moves only while running
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         pc <= '0;
      end else if (run && !stall) begin
         pc <= pc + 1'b1;
      end
   end

   assign inst = run ? imem[pc] : procPkg::nopInst;

endmodule

/* logic/decodeUnit.sv */
// Instruction decode and register file
`timescale 1ns/100ps

module decodeUnit (
   input  logic           clk,
   input  logic           arstN,
   input  procPkg::ifIdT  inst,
   input  procPkg::memWbT wbIn,
   output procPkg::idExT  decoded,
   output logic           isHaltNow,
   output logic           err
);

   logic [procPkg::dataWidth-1:0] regs [8];
   procPkg::opcodeT               op;
   logic                          illegal;

   assign op = procPkg::opcodeT'(inst.inst[15:11]);

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         for (int i = 0; i < 8; i++) begin
            regs[i] <= '0;
         end
      end else if (wbIn.regWrite) begin
         regs[wbIn.rdAddr] <= wbIn.wrData;
      end
   end

   always_comb begin
      decoded = procPkg::idExBubble;
      decoded.rsAddr = inst.inst[10:8];
      decoded.rtAddr = inst.inst[7:5];
      // Write-through so a retiring result is seen this cycle
      decoded.rsVal = (wbIn.regWrite && wbIn.rdAddr == decoded.rsAddr) ?
                      wbIn.wrData : regs[decoded.rsAddr];
      decoded.rtVal = (wbIn.regWrite && wbIn.rdAddr == decoded.rtAddr) ?
                      wbIn.wrData : regs[decoded.rtAddr];
      decoded.imm = {{11{inst.inst[4]}}, inst.inst[4:0]};
      illegal = 1'b0;
      isHaltNow = 1'b0;
      case (op)
         procPkg::OpAdd, procPkg::OpSub, procPkg::OpAnd, procPkg::OpXor: begin
            decoded.regWrite = 1'b1;
            decoded.rdAddr = inst.inst[4:2];
            if (op == procPkg::OpSub) decoded.aluOp = procPkg::Sub;
            if (op == procPkg::OpAnd) decoded.aluOp = procPkg::And;
            if (op == procPkg::OpXor) decoded.aluOp = procPkg::Xor;
         end
         procPkg::OpAddi, procPkg::OpLd: begin
            decoded.useImm = 1'b1;
            decoded.regWrite = 1'b1;
            decoded.memRead = (op == procPkg::OpLd);
            decoded.rdAddr = inst.inst[7:5];
         end
         procPkg::OpSt: begin
            decoded.useImm = 1'b1;
            decoded.memWrite = 1'b1;
         end
         procPkg::OpHalt: begin
            decoded.isHalt = 1'b1;
            isHaltNow = 1'b1;
         end
         procPkg::OpNop: ;
         // Undefined opcodes fall through as a NOP
         default: illegal = 1'b1;
      endcase
   end

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         err <= 1'b0;
      end else if (illegal) begin
         err <= 1'b1;
      end
   end

endmodule

/* logic/hazardUnit.sv */
// Load-use stall and halt freeze
`timescale 1ns/100ps

module hazardUnit (
   input  logic [procPkg::regAddrWidth-1:0] rsAddr,
   input  logic [procPkg::regAddrWidth-1:0] rtAddr,
   input  logic                             usesRt,
   input  procPkg::idExT                    idEx,
   input  logic                             haltSeen,
   output logic                             loadStall,
   output logic                             freeze
);

   logic rsHit;
   logic rtHit;

   assign rsHit = (idEx.rdAddr == rsAddr);
   assign rtHit = usesRt && (idEx.rdAddr == rtAddr);

   // Load data only exists after MEM, so decode waits one cycle
   assign loadStall = idEx.memRead && (rsHit || rtHit);

   assign freeze = haltSeen;

   // Only NOPs follow a HALT, so nothing can stall once frozen
   always_comb begin
      if (freeze) begin
         noStallWhenFrozen: assert final (!loadStall)
            else $error("load-use stall raised after halt");
      end
   end

endmodule

/* logic/forwardUnit.sv */
// Bypass source selection
`timescale 1ns/100ps

module forwardUnit (
   input  procPkg::idExT   idEx,
   input  procPkg::exMemT  exMem,
   input  procPkg::memWbT  memWb,
   output procPkg::fwdSelT fwdRs,
   output procPkg::fwdSelT fwdRt,
   output logic            fwdStore
);

   function automatic procPkg::fwdSelT pickSrc(
      input logic [procPkg::regAddrWidth-1:0] src,
      input procPkg::exMemT                   ex,
      input procPkg::memWbT                   wb
   );
      // Younger EX/MEM result wins, loads are not ready there yet
      if (ex.regWrite && !ex.memRead && ex.rdAddr == src) begin
         return procPkg::FromExMem;
      end else if (wb.regWrite && wb.rdAddr == src) begin
         return procPkg::FromMemWb;
      end
      return procPkg::FromReg;
   endfunction

   assign fwdRs = pickSrc(idEx.rsAddr, exMem, memWb);
   assign fwdRt = pickSrc(idEx.rtAddr, exMem, memWb);

   // Store data can still pick up a load that retired right behind it
   assign fwdStore = exMem.memWrite && memWb.regWrite && (memWb.rdAddr == exMem.rtAddr);

   // The hazard unit must keep a load's consumer out of EX
   always_comb begin
      if (exMem.memRead && (idEx.regWrite || idEx.memWrite)) begin
         loadNotBypassed: assert final (exMem.rdAddr != idEx.rsAddr &&
                                        (idEx.useImm || exMem.rdAddr != idEx.rtAddr))
            else $error("load result needed in EX without a stall");
      end
   end

endmodule

/* logic/executeUnit.sv */
// Operand select and ALU
`timescale 1ns/100ps

module executeUnit (
   input  procPkg::idExT                 idEx,
   input  logic [procPkg::dataWidth-1:0] exMemData,
   input  logic [procPkg::dataWidth-1:0] memWbData,
   input  procPkg::fwdSelT               fwdRs,
   input  procPkg::fwdSelT               fwdRt,
   output procPkg::exMemT                result
);

   logic [procPkg::dataWidth-1:0] opA;
   logic [procPkg::dataWidth-1:0] rtOp;
   logic [procPkg::dataWidth-1:0] opB;

   always_comb begin
      case (fwdRs)
         procPkg::FromExMem: opA = exMemData;
         procPkg::FromMemWb: opA = memWbData;
         default:            opA = idEx.rsVal;
      endcase
      case (fwdRt)
         procPkg::FromExMem: rtOp = exMemData;
         procPkg::FromMemWb: rtOp = memWbData;
         default:            rtOp = idEx.rtVal;
      endcase
      opB = idEx.useImm ? idEx.imm : rtOp;

      case (idEx.aluOp)
         procPkg::Sub: result.aluRes = opA - opB;
         procPkg::And: result.aluRes = opA & opB;
         procPkg::Xor: result.aluRes = opA ^ opB;
         default:      result.aluRes = opA + opB;
      endcase
      result.storeData = rtOp;
      result.rtAddr = idEx.rtAddr;
      result.rdAddr = idEx.rdAddr;
      result.regWrite = idEx.regWrite;
      result.memRead = idEx.memRead;
      result.memWrite = idEx.memWrite;
      result.isHalt = idEx.isHalt;
   end

endmodule

/* logic/dataMem.sv */
// Data memory
`timescale 1ns/100ps

module dataMem (
   input  logic                              clk,
   input  procPkg::exMemT                    exMem,
   input  logic [procPkg::dataWidth-1:0]     storeData,
   input  logic [procPkg::dataAddrWidth-1:0] dbgAddr,
   output logic [procPkg::dataWidth-1:0]     dbgData,
   output procPkg::memWbT                    wbOut
);

   logic [procPkg::dataWidth-1:0]     mem [procPkg::dataWords];
   logic [procPkg::dataAddrWidth-1:0] addr;

   // Word addressed, upper bits of the sum ignored
   assign addr = exMem.aluRes[procPkg::dataAddrWidth-1:0];

   always_ff @(posedge clk) begin
      if (exMem.memWrite) begin
         mem[addr] <= storeData;
      end
   end

   assign dbgData = mem[dbgAddr];

   assign wbOut.wrData = exMem.memRead ? mem[addr] : exMem.aluRes;
   assign wbOut.rdAddr = exMem.rdAddr;
   assign wbOut.regWrite = exMem.regWrite;
   assign wbOut.isHalt = exMem.isHalt;

endmodule

/* logic/procCore.sv */
// Five-stage processor core
`timescale 1ns/100ps

module procCore (
   input  logic                              clk,
   input  logic                              arstN,
   input  logic                              run,
   input  logic                              progWe,
   input  logic [procPkg::instAddrWidth-1:0] progAddr,
   input  logic [procPkg::dataWidth-1:0]     progData,
   input  logic [procPkg::dataAddrWidth-1:0] dbgAddr,
   output logic [procPkg::dataWidth-1:0]     dbgData,
   output logic                              wbValid,
   output logic [procPkg::regAddrWidth-1:0]  wbAddr,
   output logic [procPkg::dataWidth-1:0]     wbData,
   output logic                              halted,
   output logic                              err
);

   procPkg::ifIdT   ifIdIn, ifIdQ;
   procPkg::idExT   idExD, idExQ;
   procPkg::exMemT  exMemD, exMemQ;
   procPkg::memWbT  memWbD, memWbQ, wbWrite;
   procPkg::fwdSelT fwdRs, fwdRt;
   logic            fwdStore;
   logic            loadStall;
   logic            freeze;
   logic            isHaltNow;
   logic            haltSeen;
   logic            fetchRun;
   logic            usesRt;
   logic [procPkg::dataWidth-1:0] storeData;

   // Fetch feeds NOPs from the moment a HALT reaches decode
   assign fetchRun = run && !isHaltNow && !haltSeen;

   fetchStage fetchInst (
      .clk(clk), .arstN(arstN), .run(fetchRun), .stall(loadStall),
      .progWe(progWe), .progAddr(progAddr), .progData(progData), .inst(ifIdIn.inst)
   );

   pipeReg #(.payloadT(procPkg::ifIdT)) ifIdReg (
      .clk(clk), .arstN(arstN), .hold(freeze || loadStall), .bubble(1'b0),
      .bubbleValue(procPkg::ifIdBubble), .dIn(ifIdIn), .dOut(ifIdQ)
   );

   decodeUnit decodeInst (
      .clk(clk), .arstN(arstN), .inst(ifIdQ), .wbIn(wbWrite),
      .decoded(idExD), .isHaltNow(isHaltNow), .err(err)
   );

   // Only register forms read rt in EX, store data is caught later
   assign usesRt = idExD.regWrite && !idExD.useImm;

   hazardUnit hazardInst (
      .rsAddr(idExD.rsAddr), .rtAddr(idExD.rtAddr), .usesRt(usesRt), .idEx(idExQ),
      .haltSeen(halted), .loadStall(loadStall), .freeze(freeze)
   );

   pipeReg #(.payloadT(procPkg::idExT)) idExReg (
      .clk(clk), .arstN(arstN), .hold(freeze), .bubble(loadStall),
      .bubbleValue(procPkg::idExBubble), .dIn(idExD), .dOut(idExQ)
   );

   forwardUnit forwardInst (
      .idEx(idExQ), .exMem(exMemQ), .memWb(memWbQ),
      .fwdRs(fwdRs), .fwdRt(fwdRt), .fwdStore(fwdStore)
   );

   executeUnit executeInst (
      .idEx(idExQ), .exMemData(exMemQ.aluRes), .memWbData(memWbQ.wrData),
      .fwdRs(fwdRs), .fwdRt(fwdRt), .result(exMemD)
   );

   pipeReg #(.payloadT(procPkg::exMemT)) exMemReg (
      .clk(clk), .arstN(arstN), .hold(freeze), .bubble(1'b0),
      .bubbleValue(procPkg::exMemBubble), .dIn(exMemD), .dOut(exMemQ)
   );

   assign storeData = fwdStore ? memWbQ.wrData : exMemQ.storeData;

   dataMem dataMemInst (
      .clk(clk), .exMem(exMemQ), .storeData(storeData),
      .dbgAddr(dbgAddr), .dbgData(dbgData), .wbOut(memWbD)
   );

   pipeReg #(.payloadT(procPkg::memWbT)) memWbReg (
      .clk(clk), .arstN(arstN), .hold(freeze), .bubble(1'b0),
      .bubbleValue(procPkg::memWbBubble), .dIn(memWbD), .dOut(memWbQ)
   );

   // Writeback, silenced once the core is frozen
   always_comb begin
      wbWrite = memWbQ;
      wbWrite.regWrite = memWbQ.regWrite && !freeze;
   end

   assign wbValid = wbWrite.regWrite;
   assign wbAddr = wbWrite.rdAddr;
   assign wbData = wbWrite.wrData;

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         haltSeen <= 1'b0;
         halted <= 1'b0;
      end else begin
         if (isHaltNow) haltSeen <= 1'b1;
         if (memWbQ.isHalt) halted <= 1'b1;
      end
   end

endmodule

/* verification/tbClock.sv */
// Testbench clock and reset
`timescale 1ns/100ps

module tbClock (
   input  logic resetReq,
   output logic clk,
   output logic arstN
);

   localparam int halfPeriod  = 2;
   localparam int resetCycles = 10;

   initial clk = 1'b0;
   always #(halfPeriod) clk = ~clk;

   // Reset at start and on every request, released on a falling edge
   initial begin
      arstN = 1'b0;
      forever begin
         repeat (resetCycles) @(posedge clk);
         @(negedge clk);
         arstN = 1'b1;
         @(posedge resetReq);
         arstN = 1'b0;
      end
   end

endmodule

/* verification/procTb.sv */
// Processor core testbench
`timescale 1ns/100ps

module procTb;

   localparam int dw = procPkg::dataWidth;
   localparam int aw = procPkg::regAddrWidth;
   localparam int randomPrograms = 20;
   localparam int randomLength = 30;
   localparam logic [dw-1:0] haltWord = {procPkg::OpHalt, 11'b0};
   localparam logic [4:0] validOps [8] = '{procPkg::OpAdd, procPkg::OpSub, procPkg::OpAnd,
      procPkg::OpXor, procPkg::OpAddi, procPkg::OpLd, procPkg::OpSt, procPkg::OpNop};

   logic clk;
   logic arstN;
   logic resetReq;
   logic run;
   logic progWe;
   logic [procPkg::instAddrWidth-1:0] progAddr;
   logic [dw-1:0] progData;
   logic [procPkg::dataAddrWidth-1:0] dbgAddr;
   logic [dw-1:0] dbgData;
   logic wbValid;
   logic [aw-1:0] wbAddr;
   logic [dw-1:0] wbData;
   logic halted;
   logic err;

   logic [dw-1:0] prog [procPkg::instWords];
   int progLen;
   // Starts unknown, the data memory has no reset
   logic [dw-1:0] memImg [procPkg::dataWords];
   logic [aw+dw-1:0] expQ [$];
   logic [aw+dw-1:0] expEntry;
   logic wdArmed;
   int wdLeft;
   integer seed = 16844;
   logic [31:0] rnd;

   tbClock clkGen (.resetReq(resetReq), .clk(clk), .arstN(arstN));

   procCore DUT (
      .clk(clk), .arstN(arstN), .run(run), .progWe(progWe), .progAddr(progAddr),
      .progData(progData), .dbgAddr(dbgAddr), .dbgData(dbgData), .wbValid(wbValid),
      .wbAddr(wbAddr), .wbData(wbData), .halted(halted), .err(err)
   );

   task automatic abortRun(input string why);
      $display("%s", why);
      $display("Done: errors found");
      $fatal(1);
   endtask

   task automatic check(input string name, input logic [dw-1:0] got, input logic [dw-1:0] exp);
      if (got !== exp) begin
         abortRun($sformatf("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp));
      end
   endtask

   function automatic logic [dw-1:0] encodeReg(input logic [4:0] op, input int rd, input int rs,
                                                input int rt);
      return {op, rs[2:0], rt[2:0], rd[2:0], 2'b00};
   endfunction

   function automatic logic [dw-1:0] encodeImm(input logic [4:0] op, input int rt, input int rs,
                                                input int imm);
      return {op, rs[2:0], rt[2:0], imm[4:0]};
   endfunction

   task automatic appendInst(input logic [dw-1:0] word);
      prog[progLen] = word;
      progLen++;
   endtask

   // Architectural model, one instruction at a time
   function automatic logic procModel();
      logic [dw-1:0] regs [8];
      logic [dw-1:0] w;
      logic [dw-1:0] a;
      logic [dw-1:0] b;
      logic [dw-1:0] sum;
      logic [dw-1:0] val;
      logic [aw-1:0] rd;
      logic wr;
      logic illegal;
      logic stop;
      illegal = 1'b0;
      stop = 1'b0;
      for (int r = 0; r < 8; r++) regs[r] = '0;
      expQ.delete();
      for (int pc = 0; pc < progLen && !stop; pc++) begin
         w = prog[pc];
         a = regs[w[10:8]];
         b = regs[w[7:5]];
         sum = a + {{11{w[4]}}, w[4:0]};
         wr = 1'b1;
         rd = w[4:2];
         val = '0;
         case (w[15:11])
            procPkg::OpAdd: val = a + b;
            procPkg::OpSub: val = a - b;
            procPkg::OpAnd: val = a & b;
            procPkg::OpXor: val = a ^ b;
            procPkg::OpAddi: begin
               rd = w[7:5];
               val = sum;
            end
            procPkg::OpLd: begin
               rd = w[7:5];
               val = memImg[sum[procPkg::dataAddrWidth-1:0]];
            end
            procPkg::OpSt: begin
               wr = 1'b0;
               memImg[sum[procPkg::dataAddrWidth-1:0]] = b;
            end
            procPkg::OpHalt: begin
               wr = 1'b0;
               stop = 1'b1;
            end
            procPkg::OpNop: wr = 1'b0;
            default: begin
               wr = 1'b0;
               illegal = 1'b1;
            end
         endcase
         if (wr) begin
            regs[rd] = val;
            expQ.push_back({rd, val});
         end
      end
      return illegal;
   endfunction

   task automatic runProgram();
      logic expErr;
      expErr = procModel();
      @(negedge clk);
      run = 1'b0;
      for (int a = 0; a < progLen; a++) begin
         progWe = 1'b1;
         progAddr = a[procPkg::instAddrWidth-1:0];
         progData = prog[a];
         @(negedge clk);
      end
      progWe = 1'b0;
      resetReq = 1'b1;
      @(negedge clk);
      resetReq = 1'b0;
      wait (arstN);
      @(negedge clk);
      run = 1'b1;
      wdLeft = 20 * progLen + 100;
      wdArmed = 1'b1;
      wait (halted);
      @(negedge clk);
      wdArmed = 1'b0;
      if (expQ.size() != 0) begin
         abortRun($sformatf("%0d expected register writes never retired", expQ.size()));
      end
      for (int a = 0; a < procPkg::dataWords; a++) begin
         dbgAddr = a[procPkg::dataAddrWidth-1:0];
         @(posedge clk);
         check($sformatf("dbgData[%0d]", a), dbgData, memImg[a]);
         @(negedge clk);
      end
      check("halted", halted, 1'b1);
      check("err", err, expErr);
   endtask

   // Zero 32 words around base using r1 as pointer
   task automatic clearBlock(input int base);
      int acc;
      int step;
      progLen = 0;
      acc = 0;
      while (acc < base) begin
         step = (base - acc > 15) ? 15 : base - acc;
         appendInst(encodeImm(procPkg::OpAddi, 1, 1, step));
         acc += step;
      end
      for (int imm = -16; imm < 16; imm++) appendInst(encodeImm(procPkg::OpSt, 0, 1, imm));
      appendInst(haltWord);
      runProgram();
   endtask

   always @(negedge clk) begin
      if (arstN && wbValid) begin
         if (expQ.size() == 0) begin
            abortRun("register write retired with no expected write left");
         end else begin
            expEntry = expQ.pop_front();
            check("wbAddr", wbAddr, expEntry[dw +: aw]);
            check("wbData", wbData, expEntry[dw-1:0]);
         end
      end
   end

   always @(negedge clk) begin
      if (wdArmed) begin
         if (wdLeft == 0) begin
            abortRun("halted did not rise within the cycle budget");
         end
         wdLeft = wdLeft - 1;
      end
   end

   initial begin
      run = 1'b0;
      progWe = 1'b0;
      progAddr = '0;
      progData = '0;
      dbgAddr = '0;
      resetReq = 1'b0;
      wdArmed = 1'b0;
      wdLeft = 0;
      clearBlock(16);
      clearBlock(48);

      // Independent register forms
      progLen = 0;
      for (int r = 1; r < 5; r++) appendInst(encodeImm(procPkg::OpAddi, r, 0, 3 * r - 7));
      for (int i = 0; i < 3; i++) appendInst(encodeReg(procPkg::OpNop, 0, 0, 0));
      appendInst(encodeReg(procPkg::OpAdd, 5, 1, 2));
      appendInst(encodeReg(procPkg::OpSub, 6, 3, 4));
      appendInst(encodeReg(procPkg::OpAnd, 7, 1, 3));
      appendInst(encodeReg(procPkg::OpXor, 0, 2, 4));
      appendInst(haltWord);
      runProgram();

      // Dependent chain over both bypasses and write-through
      progLen = 0;
      appendInst(encodeImm(procPkg::OpAddi, 1, 0, 3));
      appendInst(encodeReg(procPkg::OpAdd, 2, 1, 1));
      appendInst(encodeReg(procPkg::OpSub, 3, 2, 1));
      appendInst(encodeReg(procPkg::OpXor, 4, 1, 3));
      appendInst(encodeReg(procPkg::OpAnd, 5, 4, 2));
      appendInst(encodeImm(procPkg::OpAddi, 6, 5, -1));
      appendInst(haltWord);
      runProgram();

      // Load-use stalls and forwarded store data
      progLen = 0;
      appendInst(encodeImm(procPkg::OpAddi, 1, 0, 9));
      appendInst(encodeImm(procPkg::OpAddi, 2, 0, -7));
      appendInst(encodeImm(procPkg::OpSt, 2, 1, 3));
      appendInst(encodeImm(procPkg::OpLd, 3, 1, 3));
      appendInst(encodeReg(procPkg::OpAdd, 4, 3, 1));
      appendInst(encodeImm(procPkg::OpLd, 5, 1, 3));
      appendInst(encodeReg(procPkg::OpSub, 6, 1, 5));
      appendInst(encodeImm(procPkg::OpLd, 7, 0, 12));
      appendInst(encodeImm(procPkg::OpSt, 7, 0, 5));
      appendInst(encodeReg(procPkg::OpAdd, 2, 4, 6));
      appendInst(encodeImm(procPkg::OpSt, 2, 1, -3));
      appendInst(encodeImm(procPkg::OpLd, 3, 0, 5));
      appendInst(haltWord);
      runProgram();

      // Undefined opcode 11111, then nothing past HALT may retire
      progLen = 0;
      appendInst(encodeImm(procPkg::OpAddi, 1, 0, 4));
      appendInst(16'hF925);
      appendInst(encodeImm(procPkg::OpAddi, 2, 1, 1));
      appendInst(haltWord);
      appendInst(encodeImm(procPkg::OpAddi, 3, 0, 1));
      appendInst(encodeImm(procPkg::OpSt, 1, 0, 0));
      runProgram();

      for (int p = 0; p < randomPrograms; p++) begin
         progLen = 0;
         for (int i = 0; i < randomLength; i++) begin
            rnd = $random(seed);
            appendInst({validOps[rnd[13:11]], rnd[10:0]});
         end
         appendInst(haltWord);
         runProgram();
      end

      $display("Done: no errors");
      $finish;
   end

endmodule

/* list.f */
logic/procPkg.sv
logic/pipeReg.sv
logic/fetchStage.sv
logic/decodeUnit.sv
logic/hazardUnit.sv
logic/forwardUnit.sv
logic/executeUnit.sv
logic/dataMem.sv
logic/procCore.sv
verification/tbClock.sv
verification/procTb.sv

/* Bender.yml */
package:
  name: proc_core

sources:
  - logic/procPkg.sv
  - logic/pipeReg.sv
  - logic/fetchStage.sv
  - logic/decodeUnit.sv
  - logic/hazardUnit.sv
  - logic/forwardUnit.sv
  - logic/executeUnit.sv
  - logic/dataMem.sv
  - logic/procCore.sv
  - target: test
    files:
      - verification/tbClock.sv
      - verification/procTb.sv
